//--- sim/ooo_stimulus.txt
// Word 0 is the record count, then one operation per line
// group op a_kind a_val b_kind b_val expected; kind 1 means val is a distance back in dispatch order
1a
// Group 1, one of each ALU operation
1 0 0 00001234 0 00000f0f 00002143
1 1 0 00000010 0 00000020 fffffff0
1 2 0 f0f0f0f0 0 0ff00ff0 00f000f0
1 3 0 12000034 0 00567800 12567834
1 4 0 aaaa5555 0 ffff0000 55555555
1 5 0 fffffffe 0 00000003 00000001
// Group 2, dependency chain
2 0 0 00000005 0 00000007 0000000c
2 1 1 00000001 0 00000002 0000000a
2 4 1 00000001 1 00000002 00000006
// Group 3, dependent chain then independent operations
3 0 0 00000100 0 00000023 00000123
3 1 1 00000001 0 00000003 00000120
3 3 1 00000001 1 00000002 00000123
3 2 0 0000ffff 0 12345678 00005678
3 4 0 0000000f 0 000000f0 000000ff
// Group 4, retire held until the ninth operation stalls
4 0 0 00000001 0 00000001 00000002
4 0 1 00000001 1 00000001 00000004
4 0 1 00000001 1 00000001 00000008
4 1 0 00000000 0 00000001 ffffffff
4 2 1 00000001 0 0000abcd 0000abcd
4 3 1 00000003 0 00000070 00000078
4 5 0 00000005 0 00000005 00000000
4 4 1 00000001 1 00000007 00000002
4 0 1 00000001 0 00000010 00000012
// Group 5, sources name retired tags that are not yet reused
5 0 1 00000001 1 00000007 0000001a
5 1 1 00000001 1 00000005 ffffffa2
5 4 1 00000002 1 00000006 00000062

//--- tb.f
hw/core_cfg_pkg.sv
hw/uop_pkg.sv
hw/rs_slot.sv
hw/dispatch_unit.sv
hw/issue_alu.sv
hw/reorder_buffer.sv
hw/ooo_core_top.sv
sim/tb_clock_gen.sv
sim/tb_ooo_core.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_ooo_core -f tb.f -o tb_ooo_core
	out="$$(./obj_dir/tb_ooo_core)"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

//--- sim/tb_ooo_core.sv
`timescale 1ns/10ps

module tb_ooo_core;

    // Stimulus record layout, one word per column
    localparam int FIELDS     = 7;
    localparam int MAX_RECS   = 64;
    localparam int COL_GROUP  = 0;
    localparam int COL_OP     = 1;
    localparam int COL_EXP    = 6;
    // Group number of the ROB fill test
    localparam int GROUP_FILL = 4;

    // Cycle limits
    localparam int WAIT_LIMIT   = 200;
    localparam int HOLD_LIMIT   = 500;
    // Stall observed longer than any wait would tolerate
    localparam int STALL_CYCLES = WAIT_LIMIT + 40;

    // Conditions a wait loop can poll
    localparam int W_RST   = 0;
    localparam int W_ACK   = 1;
    localparam int W_RREQ  = 2;
    localparam int W_HOLD  = 3;
    localparam int W_DRAIN = 4;

    logic                   clk;
    logic                   rst_n;
    logic                   disp_req;
    uop_pkg::dispatch_uop_t disp_uop;
    logic                   disp_ack;
    logic                   retire_req;
    uop_pkg::retire_t       retire_data;
    logic                   retire_ack;

    // Word 0 holds the record count, records follow
    core_cfg_pkg::data_t stim [0:FIELDS*MAX_RECS];
    int                  num_recs;
    int                  disp_cnt;
    int                  retire_cnt;
    int                  errors;
    int                  timeouts;
    bit                  timed_out;
    // Set while the retire side must keep retire_ack low
    bit                  hold_retire;

    tb_clock_gen u_clk_gen (
        .clk(clk),
        .rst_n(rst_n)
    );

    ooo_core_top uut (
        .clk(clk), .rst_n(rst_n),
        .disp_req(disp_req), .disp_uop(disp_uop), .disp_ack(disp_ack),
        .retire_req(retire_req), .retire_data(retire_data), .retire_ack(retire_ack)
    );

    //////////////////////////////
    // Record helpers
    //////////////////////////////

    function automatic core_cfg_pkg::data_t field(input int rec, input int col);
        return stim[1 + rec*FIELDS + col];
    endfunction

    // Tags are handed out in dispatch order, wrapping at the ROB depth
    function automatic core_cfg_pkg::rob_tag_t tag_of(input int seq);
        return core_cfg_pkg::rob_tag_t'(seq % core_cfg_pkg::ROB_DEPTH);
    endfunction

    // Kind 0 is a literal, kind 1 a distance back to the producing operation
    function automatic uop_pkg::src_operand_t make_src(input int seq,
                                                       input core_cfg_pkg::data_t kind,
                                                       input core_cfg_pkg::data_t val);
        uop_pkg::src_operand_t s;
        s = '0;
        if (kind == '0) begin
            s.ready = 1'b1;
            s.value = val;
        end else begin
            s.tag   = tag_of(seq - int'(val));
            // Junk value, must be ignored while not ready
            s.value = ~val;
        end
        return s;
    endfunction

    function automatic string test_name(input int seq);
        string base;
        case (int'(field(seq, COL_GROUP)))
            1:       base = "independent_ops";
            2:       base = "wakeup_chain";
            3:       base = "in_order_retire";
            4:       base = "rob_full_stall";
            5:       base = "tag_wrap";
            default: base = "unknown_group";
        endcase
        return $sformatf("%s #%0d", base, seq);
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_data(input string name, input core_cfg_pkg::data_t exp,
                              input core_cfg_pkg::data_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input core_cfg_pkg::rob_tag_t exp,
                             input core_cfg_pkg::rob_tag_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected tag %0d, actual tag %0d", name, exp, act);
        end
    endtask

    //////////////////////////////
    // Bounded waits
    //////////////////////////////

    function automatic bit cond_met(input int kind, input logic level);
        case (kind)
            W_RST:   return rst_n === 1'b1;
            W_ACK:   return disp_ack === level;
            W_RREQ:  return retire_req === level;
            W_HOLD:  return !hold_retire;
            default: return retire_cnt == disp_cnt;
        endcase
    endfunction

    // Polls once per cycle, 1 ns after the edge, and gives up after limit cycles
    task automatic wait_for(input int kind, input logic level, input int limit,
                            input string what, output bit ok);
        int n;
        n  = 0;
        ok = 1'b1;
        while (!cond_met(kind, level)) begin
            // Other process already gave up
            if (timed_out) begin
                ok = 1'b0;
                return;
            end
            if (n >= limit) begin
                timeouts++;
                timed_out = 1'b1;
                ok = 1'b0;
                $display("Timed out after %0d cycles waiting for %s", limit, what);
                return;
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////
    // Dispatch side
    //////////////////////////////

    // ROB is full, so the request must sit unanswered
    task automatic check_stall(input int seq);
        int n;
        for (n = 0; n < STALL_CYCLES; n++) begin
            @(posedge clk);
            #1;
            if (disp_ack) begin
                errors++;
                $display("CHECK FAILED %s: expected disp_ack 0, actual 1", test_name(seq));
                return;
            end
        end
    endtask

    task automatic dispatch_one(input int seq, output bit ok);
        idle_cycles(int'($urandom % 4));
        disp_uop.op    = uop_pkg::alu_op_e'(3'(field(seq, COL_OP)));
        disp_uop.src_a = make_src(seq, field(seq, 2), field(seq, 3));
        disp_uop.src_b = make_src(seq, field(seq, 4), field(seq, 5));
        disp_req       = 1'b1;
        // Eight outstanding with retire held, this one has to wait
        if (hold_retire && (disp_cnt - retire_cnt) == core_cfg_pkg::ROB_DEPTH) begin
            check_stall(seq);
            hold_retire = 1'b0;
        end
        wait_for(W_ACK, 1'b1, WAIT_LIMIT, "disp_ack to rise", ok);
        if (!ok) begin
            return;
        end
        disp_req = 1'b0;
        disp_cnt++;
        wait_for(W_ACK, 1'b0, WAIT_LIMIT, "disp_ack to fall", ok);
    endtask

    task automatic dispatch_all();
        bit ok;
        int seq;
        int grp;
        int prev_grp;
        prev_grp = 0;
        for (seq = 0; seq < num_recs; seq++) begin
            grp = int'(field(seq, COL_GROUP));
            // Every group starts from an empty ROB
            if (grp != prev_grp) begin
                if (hold_retire) begin
                    errors++;
                    $display("Reorder buffer never filled while retire_ack was held");
                end
                hold_retire = 1'b0;
                wait_for(W_DRAIN, 1'b0, WAIT_LIMIT, "reorder buffer to drain", ok);
                if (!ok) begin
                    return;
                end
                hold_retire = (grp == GROUP_FILL);
                prev_grp    = grp;
            end
            dispatch_one(seq, ok);
            if (!ok) begin
                return;
            end
        end
        wait_for(W_DRAIN, 1'b0, WAIT_LIMIT, "final retirements", ok);
    endtask

    //////////////////////////////
    // Retire side
    //////////////////////////////

    // Retirements must come back in file order with sequential tags
    task automatic retire_all();
        bit    ok;
        string name;
        while (retire_cnt < num_recs && !timed_out) begin
            wait_for(W_RREQ, 1'b1, WAIT_LIMIT, "retire_req to rise", ok);
            if (!ok) begin
                return;
            end
            wait_for(W_HOLD, 1'b0, HOLD_LIMIT, "release of retire_ack", ok);
            if (!ok) begin
                return;
            end
            idle_cycles(int'($urandom % 5));
            name = test_name(retire_cnt);
            check_tag(name, tag_of(retire_cnt), retire_data.tag);
            check_data(name, field(retire_cnt, COL_EXP), retire_data.value);
            retire_ack = 1'b1;
            wait_for(W_RREQ, 1'b0, WAIT_LIMIT, "retire_req to fall", ok);
            if (!ok) begin
                return;
            end
            retire_cnt++;
            retire_ack = 1'b0;
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        bit ok;
        disp_req    = 1'b0;
        disp_uop    = '0;
        retire_ack  = 1'b0;
        errors      = 0;
        timeouts    = 0;
        timed_out   = 1'b0;
        hold_retire = 1'b0;
        disp_cnt    = 0;
        retire_cnt  = 0;
        num_recs    = 0;
        void'($urandom(32'h27b4_029e));

        $readmemh("sim/ooo_stimulus.txt", stim);
        if ($isunknown(stim[0]) || stim[0] == '0 || stim[0] > MAX_RECS) begin
            errors++;
            $display("Stimulus file sim/ooo_stimulus.txt is missing or has a bad record count");
        end else begin
            num_recs = int'(stim[0]);
        end

        wait_for(W_RST, 1'b1, WAIT_LIMIT, "reset release", ok);
        @(posedge clk);
        #1;

        // Both handshakes run side by side
        fork
            dispatch_all();
            retire_all();
        join

        $display("Finished: %0d dispatched, %0d retired, %0d check errors, %0d timeouts",
                 disp_cnt, retire_cnt, errors, timeouts);
        if (errors == 0 && timeouts == 0 && retire_cnt == num_recs) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held low for 5 rising edges, released just after the last one
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- hw/ooo_core_top.sv
`timescale 1ns/10ps

module ooo_core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  disp_req,
    input  uop_pkg::dispatch_uop_t disp_uop,
    output logic                  disp_ack,
    output logic                  retire_req,
    output uop_pkg::retire_t      retire_data,
    input  logic                  retire_ack
);

    // Slot status and control
    core_cfg_pkg::slot_vec_t slot_busy;
    core_cfg_pkg::slot_vec_t slot_ready;
    core_cfg_pkg::slot_vec_t slot_write;
    core_cfg_pkg::slot_vec_t grant;
    uop_pkg::rs_entry_t      new_entry;
    uop_pkg::rs_entry_t      slot_entries [core_cfg_pkg::RS_SLOTS];

    // Result bus shared by slots, dispatch and ROB
    uop_pkg::result_bcast_t bcast;

    // Dispatch to ROB
    logic                   rob_full;
    logic                   rob_alloc;
    core_cfg_pkg::rob_tag_t rob_next_tag;
    core_cfg_pkg::rob_tag_t lookup_tag_a;
    core_cfg_pkg::rob_tag_t lookup_tag_b;
    uop_pkg::rob_lookup_t   lookup_a;
    uop_pkg::rob_lookup_t   lookup_b;

    dispatch_unit u_dispatch (
        .clk(clk), .rst_n(rst_n),
        .disp_req(disp_req), .disp_uop(disp_uop), .disp_ack(disp_ack),
        .slot_busy(slot_busy), .slot_write(slot_write), .new_entry(new_entry),
        .rob_full(rob_full), .rob_next_tag(rob_next_tag), .rob_alloc(rob_alloc),
        .lookup_tag_a(lookup_tag_a), .lookup_tag_b(lookup_tag_b),
        .lookup_a(lookup_a), .lookup_b(lookup_b),
        .bcast(bcast)
    );

    // Identical reservation station entries
    for (genvar i = 0; i < core_cfg_pkg::RS_SLOTS; i++) begin : g_slot
        rs_slot u_slot (
            .clk(clk), .rst_n(rst_n),
            .write(slot_write[i]), .entry_in(new_entry),
            .grant(grant[i]), .bcast(bcast),
            .busy(slot_busy[i]), .ready(slot_ready[i]), .entry(slot_entries[i])
        );
    end

    issue_alu u_issue (
        .clk(clk), .rst_n(rst_n),
        .slot_ready(slot_ready), .slot_entries(slot_entries),
        .grant(grant), .bcast(bcast)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst_n(rst_n),
        .alloc(rob_alloc), .full(rob_full), .next_tag(rob_next_tag),
        .lookup_tag_a(lookup_tag_a), .lookup_tag_b(lookup_tag_b),
        .lookup_a(lookup_a), .lookup_b(lookup_b),
        .bcast(bcast),
        .retire_req(retire_req), .retire_data(retire_data), .retire_ack(retire_ack)
    );

endmodule

//--- hw/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc,
    output logic                   full,
    output core_cfg_pkg::rob_tag_t next_tag,
    input  core_cfg_pkg::rob_tag_t lookup_tag_a,
    input  core_cfg_pkg::rob_tag_t lookup_tag_b,
    output uop_pkg::rob_lookup_t   lookup_a,
    output uop_pkg::rob_lookup_t   lookup_b,
    input  uop_pkg::result_bcast_t bcast,
    output logic                   retire_req,
    output uop_pkg::retire_t       retire_data,
    input  logic                   retire_ack
);

    core_cfg_pkg::rob_tag_t            head;
    core_cfg_pkg::rob_tag_t            tail;
    core_cfg_pkg::rob_count_t          count;
    logic [core_cfg_pkg::ROB_DEPTH-1:0] busy;
    logic [core_cfg_pkg::ROB_DEPTH-1:0] finished;
    core_cfg_pkg::data_t               values [core_cfg_pkg::ROB_DEPTH];
    uop_pkg::hs_state_e                rt_state;
    logic                              head_done;
    logic                              retire_fire;

    //////////////////////////////
    // Status
    //////////////////////////////

    assign full     = (count == core_cfg_pkg::rob_count_t'(core_cfg_pkg::ROB_DEPTH));
    assign next_tag = tail;

    // Head allocated and its result is in
    assign head_done = busy[head] && finished[head];

    // Head leaves on the edge where ack meets a raised req
    assign retire_fire = (rt_state == uop_pkg::IDLE) && retire_req && retire_ack;

    // Finished stays set past retirement, cleared when the tag is reused
    assign lookup_a = '{finished: finished[lookup_tag_a], value: values[lookup_tag_a]};
    assign lookup_b = '{finished: finished[lookup_tag_b], value: values[lookup_tag_b]};

    assign retire_data = '{tag: head, value: values[head]};

    //////////////////////////////
    // Pointers and entry flags
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            busy     <= '0;
            finished <= '0;
        end else begin
            // New operation at the tail
            if (alloc) begin
                busy[tail]     <= 1'b1;
                finished[tail] <= 1'b0;
                tail           <= tail + 1'b1;
            end
            // Completion from the ALU, any order
            if (bcast.valid) begin
                finished[bcast.tag] <= 1'b1;
            end
            // Retire strictly from the head
            if (retire_fire) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (alloc && !retire_fire) begin
                count <= count + 1'b1;
            end else if (!alloc && retire_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    // Result storage
    always_ff @(posedge clk) begin
        if (bcast.valid) begin
            values[bcast.tag] <= bcast.value;
        end
    end

    //////////////////////////////
    // Retire handshake
    //////////////////////////////

    // IDLE raises req and waits for ack, WAIT_LOW waits for ack to drop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_req <= 1'b0;
            rt_state   <= uop_pkg::IDLE;
        end else begin
            case (rt_state)
                uop_pkg::IDLE: begin
                    if (retire_fire) begin
                        retire_req <= 1'b0;
                        rt_state   <= uop_pkg::WAIT_LOW;
                    end else if (head_done) begin
                        retire_req <= 1'b1;
                    end
                end
                uop_pkg::WAIT_LOW: begin
                    if (!retire_ack) begin
                        rt_state <= uop_pkg::IDLE;
                    end
                end
                default: rt_state <= uop_pkg::IDLE;
            endcase
        end
    end

    // Dispatch honours back-pressure
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc |-> !full
    );

    // Each allocated operation completes exactly once
    a_bcast_live: assert property (
        @(posedge clk) disable iff (!rst_n)
        bcast.valid |-> (busy[bcast.tag] && !finished[bcast.tag])
    );

endmodule

//--- hw/issue_alu.sv
`timescale 1ns/10ps

module issue_alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  core_cfg_pkg::slot_vec_t slot_ready,
    input  uop_pkg::rs_entry_t      slot_entries [core_cfg_pkg::RS_SLOTS],
    output core_cfg_pkg::slot_vec_t grant,
    output uop_pkg::result_bcast_t  bcast
);

    uop_pkg::rs_entry_t     sel;
    core_cfg_pkg::data_t    op_a;
    core_cfg_pkg::data_t    op_b;
    core_cfg_pkg::data_t    alu_out;
    logic                   res_valid;
    core_cfg_pkg::rob_tag_t res_tag;
    core_cfg_pkg::data_t    res_value;

    //////////////////////////////
    // Select
    //////////////////////////////

    // Lowest set bit of the ready vector
    assign grant = slot_ready & (~slot_ready + core_cfg_pkg::slot_vec_t'(1));

    // Granted entry, one-hot so a plain scan is enough
    always_comb begin
        sel = '0;
        for (int i = 0; i < core_cfg_pkg::RS_SLOTS; i++) begin
            if (grant[i]) begin
                sel = slot_entries[i];
            end
        end
    end

    //////////////////////////////
    // Simple ALU
    //////////////////////////////

    assign op_a = sel.src_a.value;
    assign op_b = sel.src_b.value;

    always_comb begin
        case (sel.op)
            uop_pkg::ADD: alu_out = op_a + op_b;
            uop_pkg::SUB: alu_out = op_a - op_b;
            uop_pkg::AND: alu_out = op_a & op_b;
            uop_pkg::OR:  alu_out = op_a | op_b;
            uop_pkg::XOR: alu_out = op_a ^ op_b;
            // Signed compare, result is 0 or 1
            uop_pkg::SLT: alu_out = ($signed(op_a) < $signed(op_b)) ?
                                    core_cfg_pkg::data_t'(1) : '0;
            default:      alu_out = '0;
        endcase
    end

    // Result goes on the bus one cycle after grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= |grant;
        end
    end

    always_ff @(posedge clk) begin
        res_tag   <= sel.tag;
        res_value <= alu_out;
    end

    assign bcast = '{valid: res_valid, tag: res_tag, value: res_value};

    // Single issue per cycle, and only from slots that reported ready
    a_grant_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && ((grant & ~slot_ready) == '0)
    );

endmodule

//--- hw/dispatch_unit.sv
`timescale 1ns/10ps

module dispatch_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    disp_req,
    input  uop_pkg::dispatch_uop_t  disp_uop,
    output logic                    disp_ack,
    input  core_cfg_pkg::slot_vec_t slot_busy,
    output core_cfg_pkg::slot_vec_t slot_write,
    output uop_pkg::rs_entry_t      new_entry,
    input  logic                    rob_full,
    input  core_cfg_pkg::rob_tag_t  rob_next_tag,
    output logic                    rob_alloc,
    output core_cfg_pkg::rob_tag_t  lookup_tag_a,
    output core_cfg_pkg::rob_tag_t  lookup_tag_b,
    input  uop_pkg::rob_lookup_t    lookup_a,
    input  uop_pkg::rob_lookup_t    lookup_b,
    input  uop_pkg::result_bcast_t  bcast
);

    uop_pkg::hs_state_e      state;
    core_cfg_pkg::slot_vec_t free_onehot;
    logic                    accept;
    uop_pkg::src_operand_t   src_a_res;
    uop_pkg::src_operand_t   src_b_res;

    // Fill in a waiting source
    // Same-cycle result wins, then a value already parked in the ROB
    function automatic uop_pkg::src_operand_t resolve_src(
        input uop_pkg::src_operand_t src,
        input uop_pkg::rob_lookup_t  lk,
        input uop_pkg::result_bcast_t bc
    );
        uop_pkg::src_operand_t res;
        res = src;
        if (!src.ready) begin
            if (bc.valid && (bc.tag == src.tag)) begin
                res.ready = 1'b1;
                res.value = bc.value;
            end else if (lk.finished) begin
                res.ready = 1'b1;
                res.value = lk.value;
            end
        end
        return res;
    endfunction

    //////////////////////////////
    // Slot search
    //////////////////////////////

    // Lowest clear bit of the busy vector, zero when all slots are taken
    assign free_onehot = ~slot_busy & (slot_busy + core_cfg_pkg::slot_vec_t'(1));

    // Entry written only from IDLE with room in both RS and ROB
    assign accept = (state == uop_pkg::IDLE) && disp_req && (|free_onehot) && !rob_full;

    assign slot_write = accept ? free_onehot : '0;
    assign rob_alloc  = accept;

    //////////////////////////////
    // Operand capture
    //////////////////////////////

    // ROB is asked about both incoming tags every cycle
    assign lookup_tag_a = disp_uop.src_a.tag;
    assign lookup_tag_b = disp_uop.src_b.tag;

    assign src_a_res = resolve_src(disp_uop.src_a, lookup_a, bcast);
    assign src_b_res = resolve_src(disp_uop.src_b, lookup_b, bcast);

    // Tag comes from the ROB tail
    assign new_entry = '{
        op:    disp_uop.op,
        tag:   rob_next_tag,
        src_a: src_a_res,
        src_b: src_b_res
    };

    //////////////////////////////
    // Four-phase handshake
    //////////////////////////////

    // IDLE accepts, ACKED holds ack until req falls, WAIT_LOW is the dead cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= uop_pkg::IDLE;
        end else begin
            case (state)
                uop_pkg::IDLE: begin
                    if (accept) begin
                        state <= uop_pkg::ACKED;
                    end
                end
                uop_pkg::ACKED: begin
                    if (!disp_req) begin
                        state <= uop_pkg::WAIT_LOW;
                    end
                end
                uop_pkg::WAIT_LOW: state <= uop_pkg::IDLE;
                default:           state <= uop_pkg::IDLE;
            endcase
        end
    end

    // Ack rises on the write edge, falls the cycle after req drops
    assign disp_ack = (state == uop_pkg::ACKED);

    // At most one slot takes the new operation
    a_write_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        (slot_write != '0) |-> $onehot(slot_write)
    );

endmodule

//--- hw/rs_slot.sv
`timescale 1ns/10ps

module rs_slot (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   write,
    input  uop_pkg::rs_entry_t     entry_in,
    input  logic                   grant,
    input  uop_pkg::result_bcast_t bcast,
    output logic                   busy,
    output logic                   ready,
    output uop_pkg::rs_entry_t     entry
);

    logic wake_a;
    logic wake_b;

    // Result bus hits a source still waiting on that tag
    assign wake_a = bcast.valid && !entry.src_a.ready && (bcast.tag == entry.src_a.tag);
    assign wake_b = bcast.valid && !entry.src_b.ready && (bcast.tag == entry.src_b.tag);

    //////////////////////////////
    // Occupancy
    //////////////////////////////

    // Write and grant never coincide, a granted slot is busy and a written one free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (write) begin
            busy <= 1'b1;
        end else if (grant) begin
            busy <= 1'b0;
        end
    end

    //////////////////////////////
    // Entry and wakeup
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (write) begin
            entry <= entry_in;
        end else begin
            if (wake_a) begin
                entry.src_a.ready <= 1'b1;
                entry.src_a.value <= bcast.value;
            end
            if (wake_b) begin
                entry.src_b.ready <= 1'b1;
                entry.src_b.value <= bcast.value;
            end
        end
    end

    // Eligible for issue once both operands sit in the entry
    assign ready = busy && entry.src_a.ready && entry.src_b.ready;

    // Dispatch only picks slots reported free
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (!rst_n)
        write |-> !busy
    );

endmodule

//--- hw/uop_pkg.sv
package uop_pkg;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // Simple ALU operations
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5
    } alu_op_e;

    // Four-phase handshake progress
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        ACKED    = 2'd1,
        WAIT_LOW = 2'd2
    } hs_state_e;

    //////////////////////////////
    // Payloads between blocks
    //////////////////////////////

    // Ready set means value holds the operand, otherwise tag names the producer
    typedef struct packed {
        logic                  ready;
        core_cfg_pkg::rob_tag_t tag;
        core_cfg_pkg::data_t    value;
    } src_operand_t;

    // Operation as it arrives at the dispatch port
    typedef struct packed {
        alu_op_e      op;
        src_operand_t src_a;
        src_operand_t src_b;
    } dispatch_uop_t;

    // Reservation station contents, carries its own tag
    typedef struct packed {
        alu_op_e                op;
        core_cfg_pkg::rob_tag_t tag;
        src_operand_t           src_a;
        src_operand_t           src_b;
    } rs_entry_t;

    // Single result bus
    typedef struct packed {
        logic                   valid;
        core_cfg_pkg::rob_tag_t tag;
        core_cfg_pkg::data_t    value;
    } result_bcast_t;

    // Reorder buffer answer for one source tag
    typedef struct packed {
        logic                finished;
        core_cfg_pkg::data_t value;
    } rob_lookup_t;

    // In-order retirement record
    typedef struct packed {
        core_cfg_pkg::rob_tag_t tag;
        core_cfg_pkg::data_t    value;
    } retire_t;

endpackage

//--- hw/core_cfg_pkg.sv
package core_cfg_pkg;

    //////////////////////////////
    // Core sizes
    //////////////////////////////

    // Integer datapath width
    localparam int XLEN = 32;

    // Reorder buffer entries, also the tag space
    localparam int ROB_DEPTH = 8;

    // Reservation station entries for the simple ALU
    localparam int RS_SLOTS = 4;

    // Tag width follows the reorder buffer depth
    localparam int ROB_TAG_W = $clog2(ROB_DEPTH);

    //////////////////////////////
    // Vector types
    //////////////////////////////

    // Operand or result word
    typedef logic [XLEN-1:0] data_t;

    // Reorder buffer index, doubles as the operation tag
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // Occupancy count, one bit wider so a full buffer is visible
    typedef logic [ROB_TAG_W:0] rob_count_t;

    // One flag per reservation station slot
    typedef logic [RS_SLOTS-1:0] slot_vec_t;

endpackage
